/* source/cpu_pkg.sv */
package cpu_pkg;

    // basic widths
    typedef logic [31:0] u32_t;
    typedef logic [31:0] virt_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [13:0] csr_addr_t;
    typedef logic [5:0]  ecode_t;

    // kept csr numbers
    localparam csr_addr_t CSR_CRMD   = 14'h0;
    localparam csr_addr_t CSR_PRMD   = 14'h1;
    localparam csr_addr_t CSR_ECFG   = 14'h4;
    localparam csr_addr_t CSR_ESTAT  = 14'h5;
    localparam csr_addr_t CSR_ERA    = 14'h6;
    localparam csr_addr_t CSR_EENTRY = 14'hc;
    localparam csr_addr_t CSR_SAVE0  = 14'h30;

    // interrupt shares ecode 0
    localparam ecode_t ECODE_INT = 6'h0;

    // crmd fields
    localparam int CRMD_PLV_LO = 0;
    localparam int CRMD_IE     = 2;

    // prmd mirrors the crmd layout
    localparam int PRMD_PPLV_LO = 0;
    localparam int PRMD_PIE     = 2;

    // ecfg local interrupt enables
    localparam int ECFG_LIE_LO = 0;
    localparam int ECFG_LIE_W  = 13;

    // estat fields
    localparam int ESTAT_IS_LO    = 0;
    localparam int ESTAT_IS_W     = 13;
    localparam int ESTAT_HWI_LO   = 2;
    localparam int ESTAT_ECODE_LO = 16;

    // bits that a csr instruction may change
    localparam u32_t CRMD_WMASK   = 32'h0000_0007;
    localparam u32_t PRMD_WMASK   = 32'h0000_0007;
    localparam u32_t ECFG_WMASK   = 32'h0000_1fff;
    localparam u32_t ESTAT_WMASK  = 32'h0000_0003;
    localparam u32_t EENTRY_WMASK = 32'hffff_ffc0;

    // writeback slot state
    typedef enum logic [1:0] {
        WB_IDLE,
        WB_RETIRE,
        WB_TRAP
    } wb_state_e;

endpackage

/* source/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::reg_idx_t rj,
    input  cpu_pkg::reg_idx_t rkd,
    output cpu_pkg::u32_t     rj_data,
    output cpu_pkg::u32_t     rkd_data,
    input  logic              we,
    input  cpu_pkg::reg_idx_t rd,
    input  cpu_pkg::u32_t     rd_data
);
    import cpu_pkg::*;

    // r0 has no storage
    u32_t regs [1:31];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= rd_data;
        end
    end

    // read ports, no bypass from the write port
    assign rj_data  = (rj == '0) ? '0 : regs[rj];
    assign rkd_data = (rkd == '0) ? '0 : regs[rkd];

    // writeback must present a defined target with its strobe
    a_we_rd_known: assert property (
        @(posedge clk) disable iff (!rst_n) we |-> !$isunknown(rd)
    ) else $error("register write with unknown rd");

endmodule

/* source/csr_file.sv */
`timescale 1ns/1ps

module csr_file (
    input  logic               clk,
    input  logic               rst_n,
    input  cpu_pkg::csr_addr_t addr,
    output cpu_pkg::u32_t      rd_data,
    input  logic               we,
    input  cpu_pkg::u32_t      wr_data,
    input  logic [7:0]         intrpt,
    output cpu_pkg::u32_t      crmd,
    output cpu_pkg::u32_t      prmd,
    output cpu_pkg::u32_t      ecfg,
    output cpu_pkg::u32_t      estat,
    output cpu_pkg::u32_t      era,
    output cpu_pkg::u32_t      eentry,
    input  logic               excp_we,
    input  cpu_pkg::ecode_t    excp_ecode,
    input  cpu_pkg::virt_t     excp_era,
    input  logic               ertn_we
);
    import cpu_pkg::*;

    u32_t save0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            crmd   <= '0;
            prmd   <= '0;
            ecfg   <= '0;
            estat  <= '0;
            era    <= '0;
            eentry <= '0;
            save0  <= '0;
        end else begin
            // csr instruction write, masked per register
            if (we) begin
                case (addr)
                    CSR_CRMD:   crmd   <= wr_data & CRMD_WMASK;
                    CSR_PRMD:   prmd   <= wr_data & PRMD_WMASK;
                    CSR_ECFG:   ecfg   <= wr_data & ECFG_WMASK;
                    CSR_ESTAT:  estat  <= (estat & ~ESTAT_WMASK) | (wr_data & ESTAT_WMASK);
                    CSR_ERA:    era    <= wr_data;
                    CSR_EENTRY: eentry <= wr_data & EENTRY_WMASK;
                    CSR_SAVE0:  save0  <= wr_data;
                    default:    ;
                endcase
            end

            // hardware interrupt lines land in IS[9:2] every cycle
            estat[ESTAT_HWI_LO +: 8] <= intrpt;

            // events come after the instruction write and win over it
            if (excp_we) begin
                prmd[PRMD_PPLV_LO +: 2]        <= crmd[CRMD_PLV_LO +: 2];
                prmd[PRMD_PIE]                 <= crmd[CRMD_IE];
                crmd[CRMD_PLV_LO +: 2]         <= 2'b00;
                crmd[CRMD_IE]                  <= 1'b0;
                era                            <= excp_era;
                estat[ESTAT_ECODE_LO +: 6]     <= excp_ecode;
            end else if (ertn_we) begin
                crmd[CRMD_PLV_LO +: 2] <= prmd[PRMD_PPLV_LO +: 2];
                crmd[CRMD_IE]          <= prmd[PRMD_PIE];
            end
        end
    end

    // instruction read port
    always_comb begin
        case (addr)
            CSR_CRMD:   rd_data = crmd;
            CSR_PRMD:   rd_data = prmd;
            CSR_ECFG:   rd_data = ecfg;
            CSR_ESTAT:  rd_data = estat;
            CSR_ERA:    rd_data = era;
            CSR_EENTRY: rd_data = eentry;
            CSR_SAVE0:  rd_data = save0;
            default:    rd_data = '0;
        endcase
    end

    // exception unit picks one event per retire
    a_one_event: assert property (
        @(posedge clk) disable iff (!rst_n) !(excp_we && ertn_we)
    ) else $error("trap and ertn written in the same cycle");

endmodule

/* source/writeback.sv */
`timescale 1ns/1ps

module writeback (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               stall,

    // retire inputs from memory2
    input  logic               mem2_valid,
    input  cpu_pkg::virt_t     mem2_pc,
    input  cpu_pkg::u32_t      mem2_inst,
    input  logic               mem2_reg_we,
    input  cpu_pkg::reg_idx_t  mem2_rd,
    input  cpu_pkg::u32_t      mem2_result,
    input  logic               mem2_csr_we,
    input  cpu_pkg::csr_addr_t mem2_csr_addr,
    input  cpu_pkg::u32_t      mem2_csr_wdata,
    input  logic               mem2_excp,
    input  cpu_pkg::ecode_t    mem2_ecode,
    input  logic               mem2_ertn,

    input  logic               commit_block,

    // register file write
    output logic               reg_we,
    output cpu_pkg::reg_idx_t  reg_rd,
    output cpu_pkg::u32_t      reg_data,

    // csr write
    output logic               csr_we,
    output cpu_pkg::csr_addr_t csr_addr,
    output cpu_pkg::u32_t      csr_wdata,

    // to exception
    output logic               wb_valid,
    output cpu_pkg::virt_t     wb_pc,
    output logic               wb_excp,
    output cpu_pkg::ecode_t    wb_ecode,
    output logic               wb_ertn,

    // trace
    output cpu_pkg::virt_t     debug0_wb_pc,
    output logic [3:0]         debug0_wb_rf_wen,
    output cpu_pkg::reg_idx_t  debug0_wb_rf_wnum,
    output cpu_pkg::u32_t      debug0_wb_rf_wdata,
    output cpu_pkg::u32_t      debug0_wb_inst
);
    import cpu_pkg::*;

    wb_state_e state;
    wb_state_e state_next;

    // retire register payload
    virt_t     pc_q;
    u32_t      inst_q;
    logic      reg_we_q;
    reg_idx_t  rd_q;
    u32_t      result_q;
    logic      csr_we_q;
    csr_addr_t csr_addr_q;
    u32_t      csr_wdata_q;
    logic      excp_q;
    ecode_t    ecode_q;
    logic      ertn_q;

    logic flush;
    logic commit;

    // a held instruction only retires once the stall drops
    assign wb_valid = (state == WB_RETIRE) && !stall;
    assign commit   = wb_valid && !commit_block;

    // trap or ertn redirects, the next input is on the flushed path
    assign flush = wb_valid && (commit_block || ertn_q);

    always_comb begin
        state_next = state;
        if (!stall) begin
            if (flush) begin
                state_next = WB_TRAP;
            end else if (mem2_valid) begin
                state_next = WB_RETIRE;
            end else begin
                state_next = WB_IDLE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= WB_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pc_q        <= mem2_pc;
            inst_q      <= mem2_inst;
            reg_we_q    <= mem2_reg_we;
            rd_q        <= mem2_rd;
            result_q    <= mem2_result;
            csr_we_q    <= mem2_csr_we;
            csr_addr_q  <= mem2_csr_addr;
            csr_wdata_q <= mem2_csr_wdata;
            excp_q      <= mem2_excp;
            ecode_q     <= mem2_ecode;
            ertn_q      <= mem2_ertn;
        end
    end

    assign reg_we   = commit && reg_we_q;
    assign reg_rd   = rd_q;
    assign reg_data = result_q;

    assign csr_we    = commit && csr_we_q;
    assign csr_addr  = csr_addr_q;
    assign csr_wdata = csr_wdata_q;

    assign wb_pc    = pc_q;
    assign wb_excp  = excp_q;
    assign wb_ecode = ecode_q;
    assign wb_ertn  = ertn_q;

    assign debug0_wb_pc       = pc_q;
    assign debug0_wb_rf_wen   = {4{reg_we}};
    assign debug0_wb_rf_wnum  = rd_q;
    assign debug0_wb_rf_wdata = result_q;
    assign debug0_wb_inst     = inst_q;

    // memory2 hands over defined control bits with its valid
    a_ctrl_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        (mem2_valid && !stall) |->
            !$isunknown({mem2_reg_we, mem2_csr_we, mem2_excp, mem2_ertn})
    ) else $error("retire input with unknown control bits");

endmodule

/* source/exception.sv */
`timescale 1ns/1ps

module exception (
    input  logic            wb_valid,
    input  cpu_pkg::virt_t  wb_pc,
    input  logic            wb_excp,
    input  cpu_pkg::ecode_t wb_ecode,
    input  logic            wb_ertn,

    // csr state
    input  cpu_pkg::u32_t   crmd,
    input  cpu_pkg::u32_t   prmd,
    input  cpu_pkg::u32_t   ecfg,
    input  cpu_pkg::u32_t   estat,
    input  cpu_pkg::u32_t   era,
    input  cpu_pkg::u32_t   eentry,

    // csr update
    output logic            excp_we,
    output cpu_pkg::ecode_t excp_ecode,
    output cpu_pkg::virt_t  excp_era,
    output logic            ertn_we,

    output logic            commit_block,
    output logic            redirect_valid,
    output cpu_pkg::virt_t  redirect_pc
);
    import cpu_pkg::*;

    logic int_pending;
    logic trap;

    // any enabled interrupt line while globally enabled
    assign int_pending = |(estat[ESTAT_IS_LO +: ESTAT_IS_W] & ecfg[ECFG_LIE_LO +: ECFG_LIE_W])
                         && crmd[CRMD_IE];

    // interrupt first, then the instruction's own exception
    assign trap = wb_valid && (int_pending || wb_excp);

    assign excp_we    = trap;
    assign excp_ecode = int_pending ? ECODE_INT : wb_ecode;
    assign excp_era   = wb_pc;

    // ertn only when nothing outranks it
    assign ertn_we = wb_valid && wb_ertn && !trap;

    assign commit_block   = trap;
    assign redirect_valid = trap || ertn_we;
    assign redirect_pc    = trap ? eentry : era;

    // restoring an undefined mode would corrupt crmd
    always_comb begin
        if (ertn_we) begin
            a_prmd_known: assert #0 (!$isunknown(prmd[PRMD_PPLV_LO +: 3]))
                else $error("ertn with unknown prmd");
        end
    end

endmodule

/* source/commit_top.sv */
`timescale 1ns/1ps

module commit_top (
    input  logic               clk,
    input  logic               rst_n,

    // retire from memory2
    input  logic               mem2_valid,
    input  cpu_pkg::virt_t     mem2_pc,
    input  cpu_pkg::u32_t      mem2_inst,
    input  logic               mem2_reg_we,
    input  cpu_pkg::reg_idx_t  mem2_rd,
    input  cpu_pkg::u32_t      mem2_result,
    input  logic               mem2_csr_we,
    input  cpu_pkg::csr_addr_t mem2_csr_addr,
    input  cpu_pkg::u32_t      mem2_csr_wdata,
    input  logic               mem2_excp,
    input  cpu_pkg::ecode_t    mem2_ecode,
    input  logic               mem2_ertn,

    input  logic               stall_wb,
    input  logic [7:0]         intrpt,

    // decode read ports
    input  cpu_pkg::reg_idx_t  id_rj,
    input  cpu_pkg::reg_idx_t  id_rkd,
    output cpu_pkg::u32_t      id_rj_data,
    output cpu_pkg::u32_t      id_rkd_data,
    input  cpu_pkg::csr_addr_t id_csr_addr,
    output cpu_pkg::u32_t      id_csr_data,

    // fetch redirect
    output logic               redirect_valid,
    output cpu_pkg::virt_t     redirect_pc,

    // trace
    output cpu_pkg::virt_t     debug0_wb_pc,
    output logic [3:0]         debug0_wb_rf_wen,
    output cpu_pkg::reg_idx_t  debug0_wb_rf_wnum,
    output cpu_pkg::u32_t      debug0_wb_rf_wdata,
    output cpu_pkg::u32_t      debug0_wb_inst
);
    import cpu_pkg::*;

    // register write
    logic     reg_we;
    reg_idx_t reg_rd;
    u32_t     reg_data;

    // csr port, shared between decode read and writeback write
    logic      csr_we;
    csr_addr_t csr_addr_wb;
    csr_addr_t csr_addr;
    u32_t      csr_wdata;
    assign csr_addr = csr_we ? csr_addr_wb : id_csr_addr;

    // retiring instruction
    logic   wb_valid;
    virt_t  wb_pc;
    logic   wb_excp;
    ecode_t wb_ecode;
    logic   wb_ertn;

    // csr state to exception
    u32_t crmd, prmd, ecfg, estat, era, eentry;

    // exception results
    logic   excp_we;
    ecode_t excp_ecode;
    virt_t  excp_era;
    logic   ertn_we;
    logic   commit_block;

    reg_file u_reg_file (
        .clk, .rst_n,
        .rj(id_rj),
        .rkd(id_rkd),
        .rj_data(id_rj_data),
        .rkd_data(id_rkd_data),
        .we(reg_we),
        .rd(reg_rd),
        .rd_data(reg_data)
    );

    csr_file u_csr_file (
        .clk, .rst_n,
        .addr(csr_addr),
        .rd_data(id_csr_data),
        .we(csr_we),
        .wr_data(csr_wdata),
        .intrpt,
        .crmd, .prmd, .ecfg, .estat, .era, .eentry,
        .excp_we,
        .excp_ecode,
        .excp_era,
        .ertn_we
    );

    writeback u_writeback (
        .clk, .rst_n,
        .stall(stall_wb),
        .mem2_valid, .mem2_pc, .mem2_inst,
        .mem2_reg_we, .mem2_rd, .mem2_result,
        .mem2_csr_we, .mem2_csr_addr, .mem2_csr_wdata,
        .mem2_excp, .mem2_ecode, .mem2_ertn,
        .commit_block,
        .reg_we, .reg_rd, .reg_data,
        .csr_we,
        .csr_addr(csr_addr_wb),
        .csr_wdata,
        .wb_valid, .wb_pc, .wb_excp, .wb_ecode, .wb_ertn,
        .debug0_wb_pc, .debug0_wb_rf_wen, .debug0_wb_rf_wnum,
        .debug0_wb_rf_wdata, .debug0_wb_inst
    );

    exception u_exception (
        .wb_valid, .wb_pc, .wb_excp, .wb_ecode, .wb_ertn,
        .crmd, .prmd, .ecfg, .estat, .era, .eentry,
        .excp_we, .excp_ecode, .excp_era, .ertn_we,
        .commit_block,
        .redirect_valid,
        .redirect_pc
    );

endmodule

/* bench/commit_checker.sv */
`timescale 1ns/1ps

module commit_checker (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               mem2_valid,
    input  cpu_pkg::virt_t     mem2_pc,
    input  cpu_pkg::u32_t      mem2_inst,
    input  logic               mem2_reg_we,
    input  cpu_pkg::reg_idx_t  mem2_rd,
    input  cpu_pkg::u32_t      mem2_result,
    input  logic               mem2_csr_we,
    input  cpu_pkg::csr_addr_t mem2_csr_addr,
    input  cpu_pkg::u32_t      mem2_csr_wdata,
    input  logic               mem2_excp,
    input  cpu_pkg::ecode_t    mem2_ecode,
    input  logic               mem2_ertn,
    input  logic               stall_wb,
    input  logic [7:0]         intrpt,
    input  cpu_pkg::reg_idx_t  id_rj,
    input  cpu_pkg::reg_idx_t  id_rkd,
    input  cpu_pkg::u32_t      id_rj_data,
    input  cpu_pkg::u32_t      id_rkd_data,
    input  cpu_pkg::csr_addr_t id_csr_addr,
    input  cpu_pkg::u32_t      id_csr_data,
    input  logic               redirect_valid,
    input  cpu_pkg::virt_t     redirect_pc,
    input  cpu_pkg::virt_t     debug0_wb_pc,
    input  logic [3:0]         debug0_wb_rf_wen,
    input  cpu_pkg::reg_idx_t  debug0_wb_rf_wnum,
    input  cpu_pkg::u32_t      debug0_wb_rf_wdata,
    input  cpu_pkg::u32_t      debug0_wb_inst,
    // expected reads from the stimulus table
    input  logic               chk_read,
    input  cpu_pkg::u32_t      exp_rj,
    input  cpu_pkg::u32_t      exp_csr,
    output int                 err_count
);
    import cpu_pkg::*;

    // architectural state as the commit rules describe it
    u32_t        m_regs [0:31];
    logic        m_ie;
    logic        m_pie;
    logic [12:0] m_lie;
    logic [1:0]  m_sw;
    logic [7:0]  m_hwi;
    virt_t       m_era;
    virt_t       m_eentry;

    // instruction sitting in writeback
    logic      s_valid;
    virt_t     s_pc;
    u32_t      s_inst;
    logic      s_reg_we;
    reg_idx_t  s_rd;
    u32_t      s_result;
    logic      s_csr_we;
    csr_addr_t s_csr_addr;
    u32_t      s_csr_wdata;
    logic      s_excp;
    logic      s_ertn;

    task report_mismatch(input string what, input u32_t got, input u32_t want);
        err_count++;
        $display("error at %0t: %s is %h, expected %h", $time, what, got, want);
    endtask

    // masks follow the writable fields of each csr
    task apply_csr_write(input csr_addr_t addr, input u32_t data);
        case (addr)
            CSR_CRMD:   m_ie = data[2];
            CSR_PRMD:   m_pie = data[2];
            CSR_ECFG:   m_lie = data[12:0];
            CSR_ESTAT:  m_sw = data[1:0];
            CSR_ERA:    m_era = data;
            CSR_EENTRY: m_eentry = {data[31:6], 6'b0};
            default:    ;
        endcase
    endtask

    always @(posedge clk) begin : watch
        logic        live;
        logic        irq;
        logic        trap;
        logic        ret;
        logic        e_redir;
        logic        csr_busy;
        logic [12:0] is_bits;
        virt_t       e_pc;
        logic [3:0]  e_wen;
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                m_regs[i] = '0;
            end
            m_ie     = 1'b0;
            m_pie    = 1'b0;
            m_lie    = '0;
            m_sw     = '0;
            m_hwi    = '0;
            m_era    = '0;
            m_eentry = '0;
            s_valid  = 1'b0;
        end else begin
            is_bits = {3'b000, m_hwi, m_sw};
            live    = s_valid && !stall_wb;
            irq     = |(is_bits & m_lie) && m_ie;
            trap    = live && (irq || s_excp);
            ret     = live && s_ertn && !trap;
            e_redir = trap || ret;
            e_pc    = trap ? m_eentry : m_era;
            e_wen   = (live && !trap && s_reg_we) ? 4'hf : 4'h0;

            if (redirect_valid !== e_redir)
                report_mismatch("redirect_valid", redirect_valid, e_redir);
            if (e_redir && redirect_pc !== e_pc)
                report_mismatch("redirect_pc", redirect_pc, e_pc);
            if (debug0_wb_rf_wen !== e_wen)
                report_mismatch("debug0_wb_rf_wen", debug0_wb_rf_wen, e_wen);
            if (e_wen != 4'h0) begin
                if (debug0_wb_pc !== s_pc)
                    report_mismatch("debug0_wb_pc", debug0_wb_pc, s_pc);
                if (debug0_wb_inst !== s_inst)
                    report_mismatch("debug0_wb_inst", debug0_wb_inst, s_inst);
                if (debug0_wb_rf_wnum !== s_rd)
                    report_mismatch("debug0_wb_rf_wnum", debug0_wb_rf_wnum, s_rd);
                if (debug0_wb_rf_wdata !== s_result)
                    report_mismatch("debug0_wb_rf_wdata", debug0_wb_rf_wdata, s_result);
            end
            if (id_rj_data !== m_regs[id_rj])
                report_mismatch("id_rj_data vs model", id_rj_data, m_regs[id_rj]);
            if (id_rkd_data !== m_regs[id_rkd])
                report_mismatch("id_rkd_data vs model", id_rkd_data, m_regs[id_rkd]);
            if (chk_read && id_rj_data !== exp_rj)
                report_mismatch("id_rj_data vs table", id_rj_data, exp_rj);
            if (chk_read && id_csr_data !== exp_csr)
                report_mismatch("id_csr_data vs table", id_csr_data, exp_csr);

            // decode csr reads, unless writeback owns the csr port
            csr_busy = live && !trap && s_csr_we;
            if (!csr_busy && id_csr_addr == CSR_ERA && id_csr_data !== m_era)
                report_mismatch("id_csr_data era vs model", id_csr_data, m_era);
            if (!csr_busy && id_csr_addr == CSR_EENTRY && id_csr_data !== m_eentry)
                report_mismatch("id_csr_data eentry vs model", id_csr_data, m_eentry);

            // state change on this edge
            if (trap) begin
                m_pie = m_ie;
                m_ie  = 1'b0;
                m_era = s_pc;
            end else if (live) begin
                if (s_reg_we && s_rd != 5'd0)
                    m_regs[s_rd] = s_result;
                if (s_csr_we)
                    apply_csr_write(s_csr_addr, s_csr_wdata);
                if (ret)
                    m_ie = m_pie;
            end
            m_hwi = intrpt;

            // next slot, the input after a redirect is flushed
            if (!stall_wb) begin
                s_valid     = mem2_valid && !e_redir;
                s_pc        = mem2_pc;
                s_inst      = mem2_inst;
                s_reg_we    = mem2_reg_we;
                s_rd        = mem2_rd;
                s_result    = mem2_result;
                s_csr_we    = mem2_csr_we;
                s_csr_addr  = mem2_csr_addr;
                s_csr_wdata = mem2_csr_wdata;
                s_excp      = mem2_excp;
                s_ertn      = mem2_ertn;
            end
        end
    end

endmodule

/* bench/commit_tb.sv */
`timescale 1ns/1ps

module commit_tb;
    import cpu_pkg::*;

    localparam int WAIT_LIMIT = 20;

    // what a row waits for after it is applied
    localparam logic [1:0] EV_NONE   = 2'd0;
    localparam logic [1:0] EV_COMMIT = 2'd1;
    localparam logic [1:0] EV_REDIR  = 2'd2;

    typedef struct packed {
        logic       valid;
        virt_t      pc;
        logic       reg_we;
        reg_idx_t   rd;
        u32_t       result;
        logic       csr_we;
        csr_addr_t  csr_addr;
        u32_t       csr_wdata;
        logic       excp;
        ecode_t     ecode;
        logic       ertn;
        logic       stall;
        logic [7:0] intrpt;
        reg_idx_t   rj;
        csr_addr_t  csr_rd;
        logic       chk;
        u32_t       exp_rj;
        u32_t       exp_csr;
        logic [1:0] ev;
    } row_t;

    logic      clk;
    logic      rst_n;
    logic      mem2_valid;
    virt_t     mem2_pc;
    u32_t      mem2_inst;
    logic      mem2_reg_we;
    reg_idx_t  mem2_rd;
    u32_t      mem2_result;
    logic      mem2_csr_we;
    csr_addr_t mem2_csr_addr;
    u32_t      mem2_csr_wdata;
    logic      mem2_excp;
    ecode_t    mem2_ecode;
    logic      mem2_ertn;
    logic      stall_wb;
    logic [7:0] intrpt;
    reg_idx_t  id_rj;
    reg_idx_t  id_rkd;
    u32_t      id_rj_data;
    u32_t      id_rkd_data;
    csr_addr_t id_csr_addr;
    u32_t      id_csr_data;
    logic      redirect_valid;
    virt_t     redirect_pc;
    virt_t     debug0_wb_pc;
    logic [3:0] debug0_wb_rf_wen;
    reg_idx_t  debug0_wb_rf_wnum;
    u32_t      debug0_wb_rf_wdata;
    u32_t      debug0_wb_inst;

    logic chk_read;
    u32_t exp_rj;
    u32_t exp_csr;
    int   err_count;
    int   timeouts;

    row_t       rows[$];
    row_t       nr;
    logic [7:0] irq_level;

    commit_top dut_i (.*);

    commit_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task new_row(input logic valid, input virt_t pc, input logic [1:0] ev);
        nr        = '0;
        nr.valid  = valid;
        nr.pc     = pc;
        nr.ev     = ev;
        nr.intrpt = irq_level;
    endtask

    task add_reg(input virt_t pc, input reg_idx_t rd, input u32_t val, input logic [1:0] ev);
        new_row(1'b1, pc, ev);
        nr.reg_we = 1'b1;
        nr.rd     = rd;
        nr.result = val;
        rows.push_back(nr);
    endtask

    task add_csr(input virt_t pc, input csr_addr_t addr, input u32_t data);
        new_row(1'b1, pc, EV_NONE);
        nr.csr_we    = 1'b1;
        nr.csr_addr  = addr;
        nr.csr_wdata = data;
        rows.push_back(nr);
    endtask

    // a faulting instruction that also carries a register write
    task add_excp(input virt_t pc, input ecode_t ecode, input reg_idx_t rd, input u32_t val);
        new_row(1'b1, pc, EV_NONE);
        nr.excp   = 1'b1;
        nr.ecode  = ecode;
        nr.reg_we = 1'b1;
        nr.rd     = rd;
        nr.result = val;
        rows.push_back(nr);
    endtask

    task add_ertn(input virt_t pc, input logic [1:0] ev);
        new_row(1'b1, pc, ev);
        nr.ertn = 1'b1;
        rows.push_back(nr);
    endtask

    task add_idle(input logic stall, input logic [7:0] irq, input logic [1:0] ev);
        irq_level = irq;
        new_row(1'b0, '0, ev);
        nr.stall = stall;
        rows.push_back(nr);
    endtask

    // valid input presented during a stall, must be ignored
    task add_stalled(input virt_t pc, input reg_idx_t rd, input u32_t val);
        new_row(1'b1, pc, EV_NONE);
        nr.reg_we = 1'b1;
        nr.rd     = rd;
        nr.result = val;
        nr.stall  = 1'b1;
        rows.push_back(nr);
    endtask

    task add_read(input reg_idx_t rj, input u32_t rj_val, input csr_addr_t addr,
                  input u32_t csr_val);
        new_row(1'b0, '0, EV_NONE);
        nr.rj      = rj;
        nr.csr_rd  = addr;
        nr.chk     = 1'b1;
        nr.exp_rj  = rj_val;
        nr.exp_csr = csr_val;
        rows.push_back(nr);
    endtask

    task build_table;
        irq_level = 8'h00;
        // register retire, r0 stays zero
        add_reg(32'h1c00_0000, 5'd5, 32'h1111_2222, EV_COMMIT);
        add_reg(32'h1c00_0004, 5'd0, 32'hdead_beef, EV_COMMIT);
        add_read(5'd5, 32'h1111_2222, CSR_SAVE0, 32'h0);
        add_read(5'd0, 32'h0, CSR_CRMD, 32'h0);
        add_reg(32'h1c00_0008, 5'd6, 32'h3333_4444, EV_NONE);
        add_reg(32'h1c00_000c, 5'd7, 32'h5555_6666, EV_NONE);
        add_idle(1'b0, 8'h00, EV_NONE);
        add_read(5'd7, 32'h5555_6666, CSR_ECFG, 32'h0);
        // csr writes through the masks
        add_csr(32'h1c00_0010, CSR_SAVE0, 32'ha5a5_f00d);
        add_csr(32'h1c00_0014, CSR_EENTRY, 32'h1c00_8abc);
        add_csr(32'h1c00_0018, CSR_ESTAT, 32'hffff_ffff);
        add_idle(1'b0, 8'h00, EV_NONE);
        add_read(5'd5, 32'h1111_2222, CSR_SAVE0, 32'ha5a5_f00d);
        add_read(5'd6, 32'h3333_4444, CSR_EENTRY, 32'h1c00_8a80);
        add_read(5'd0, 32'h0, CSR_ESTAT, 32'h0000_0003);
        // exception, the row after it is flushed
        add_csr(32'h1c00_001c, CSR_CRMD, 32'h0000_0004);
        add_excp(32'h1c00_0020, 6'h0b, 5'd8, 32'h9999_9999);
        add_reg(32'h1c00_0024, 5'd9, 32'h7777_7777, EV_REDIR);
        add_read(5'd8, 32'h0, CSR_ERA, 32'h1c00_0020);
        add_read(5'd9, 32'h0, CSR_ESTAT, 32'h000b_0003);
        add_read(5'd0, 32'h0, CSR_CRMD, 32'h0);
        add_read(5'd0, 32'h0, CSR_PRMD, 32'h0000_0004);
        // ertn back to era
        add_ertn(32'h1c00_8a80, EV_REDIR);
        add_read(5'd0, 32'h0, CSR_CRMD, 32'h0000_0004);
        // hardware line 2 lands on IS bit 4
        add_csr(32'h1c00_0028, CSR_ECFG, 32'h0000_0010);
        add_idle(1'b0, 8'h04, EV_NONE);
        add_reg(32'h1c00_0030, 5'd10, 32'habcd_abcd, EV_REDIR);
        add_idle(1'b0, 8'h00, EV_NONE);
        add_read(5'd10, 32'h0, CSR_ESTAT, 32'h0000_0003);
        add_read(5'd0, 32'h0, CSR_ERA, 32'h1c00_0030);
        // stall over a retiring instruction
        add_reg(32'h1c00_0040, 5'd11, 32'h0bad_f00d, EV_NONE);
        repeat (4) add_stalled(32'h1c00_0044, 5'd12, 32'hffff_ffff);
        add_idle(1'b0, 8'h00, EV_COMMIT);
        add_read(5'd11, 32'h0bad_f00d, CSR_SAVE0, 32'ha5a5_f00d);
        add_read(5'd12, 32'h0, CSR_CRMD, 32'h0);
    endtask

    task drive_row(input row_t r);
        mem2_valid     = r.valid;
        mem2_pc        = r.pc;
        mem2_inst      = r.pc ^ 32'h0280_0000;
        mem2_reg_we    = r.reg_we;
        mem2_rd        = r.rd;
        mem2_result    = r.result;
        mem2_csr_we    = r.csr_we;
        mem2_csr_addr  = r.csr_addr;
        mem2_csr_wdata = r.csr_wdata;
        mem2_excp      = r.excp;
        mem2_ecode     = r.ecode;
        mem2_ertn      = r.ertn;
        stall_wb       = r.stall;
        intrpt         = r.intrpt;
        id_rj          = r.rj;
        id_csr_addr    = r.csr_rd;
        chk_read       = r.chk;
        exp_rj         = r.exp_rj;
        exp_csr        = r.exp_csr;
    endtask

    task drive_idle;
        mem2_valid = 1'b0;
        stall_wb   = 1'b0;
        chk_read   = 1'b0;
    endtask

    // outputs are looked at on rising edges, before they move
    task wait_event(input logic [1:0] ev);
        bit seen;
        int n;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < WAIT_LIMIT) begin
            @(posedge clk);
            if (ev == EV_COMMIT)
                seen = (debug0_wb_rf_wen != 4'h0);
            else
                seen = redirect_valid;
            if (!seen) begin
                @(negedge clk);
                drive_idle();
            end
            n++;
        end
        if (!seen) begin
            timeouts++;
            if (ev == EV_COMMIT)
                $display("timeout: no commit on the debug lines within %0d cycles", WAIT_LIMIT);
            else
                $display("timeout: no redirect within %0d cycles", WAIT_LIMIT);
        end
    endtask

    initial begin
        rst_n  = 1'b0;
        id_rkd = 5'd5;
        irq_level = 8'h00;
        drive_row('0);
        build_table();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < rows.size() && timeouts == 0; i++) begin
            @(negedge clk);
            drive_row(rows[i]);
            if (rows[i].ev != EV_NONE)
                wait_event(rows[i].ev);
        end
        @(negedge clk);
        drive_idle();
        repeat (3) @(negedge clk);

        $display("checker errors: %0d, timeouts: %0d", err_count, timeouts);
        if (err_count == 0 && timeouts == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* sources.f */
source/cpu_pkg.sv
source/reg_file.sv
source/csr_file.sv
source/writeback.sv
source/exception.sv
source/commit_top.sv
bench/commit_checker.sv
bench/commit_tb.sv

/* Bender.yml */
package:
  name: commit_retire

sources:
  - files:
      - source/cpu_pkg.sv
      - source/reg_file.sv
      - source/csr_file.sv
      - source/writeback.sv
      - source/exception.sv
      - source/commit_top.sv
  - target: test
    files:
      - bench/commit_checker.sv
      - bench/commit_tb.sv
